// File: design/lz_pkg.sv
package lz_pkg;

  // Window geometry.
  localparam int SYM_W     = 8;
  localparam int WIN_ROWS  = 8;
  localparam int WIN_WORDS = 2 * WIN_ROWS; // Lane A at even, lane B at odd index.
  localparam int ROW_W     = 3;
  localparam int IDX_W     = 4;
  localparam int LEN_W     = 4;

  // Token fields.
  localparam int KIND_W = 2;
  localparam int TOK_W  = 16;

  localparam logic [KIND_W-1:0] KIND_LIT       = 2'd0;
  localparam logic [KIND_W-1:0] KIND_MATCH     = 2'd1; // Run broken, next symbol carried.
  localparam logic [KIND_W-1:0] KIND_MATCH_END = 2'd2; // Flush or cap, next symbol is zero.

  // One token word, read as literal or as match depending on the kind.
  typedef union packed {
    struct packed {
      logic [TOK_W-SYM_W-1:0] pad;
      logic [SYM_W-1:0]       sym;
    } lit;
    struct packed {
      logic [IDX_W-1:0] idx;
      logic [LEN_W-1:0] len;
      logic [SYM_W-1:0] next;
    } match;
  } lz_token_u;

endpackage

// File: design/dict_ptr_gen.sv
`timescale 1ns/10ps

module dict_ptr_gen import lz_pkg::*; (
  input  logic             clk_i,
  input  logic             i_reset,
  input  logic             i_wr,
  input  logic             i_prime_wr,
  output logic [ROW_W-1:0] o_row,
  output logic             o_full
);

  localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(WIN_ROWS - 1);

  logic [ROW_W-1:0] row_q;

  // Either lane strobe moves the shared row.
  always_ff @(posedge clk_i or negedge i_reset) begin
    if (!i_reset) begin
      row_q <= '0;
    end else if (i_wr || i_prime_wr) begin
      if (row_q == LAST_ROW) begin
        row_q <= '0; // Wrap to the oldest row.
      end else begin
        row_q <= row_q + 1'b1;
      end
    end
  end

  assign o_row  = row_q;
  assign o_full = (row_q == LAST_ROW);

endmodule

// File: design/dict_window.sv
`timescale 1ns/10ps

module dict_window import lz_pkg::*; (
  input  logic                       clk_i,
  input  logic                       i_reset,
  input  logic [ROW_W-1:0]           i_row,
  input  logic                       i_wr,
  input  logic [SYM_W-1:0]           i_data,
  input  logic                       i_prime_wr,
  input  logic [SYM_W-1:0]           i_prime_data,
  output logic [WIN_WORDS*SYM_W-1:0] o_window
);

  logic [SYM_W-1:0] lane_a_q [WIN_ROWS]; // Symbol lane.
  logic [SYM_W-1:0] lane_b_q [WIN_ROWS]; // Priming lane.

  always_ff @(posedge clk_i or negedge i_reset) begin
    if (!i_reset) begin
      for (int r = 0; r < WIN_ROWS; r++) begin
        lane_a_q[r] <= '0;
      end
    end else if (i_wr) begin
      lane_a_q[i_row] <= i_data;
    end
  end

  always_ff @(posedge clk_i or negedge i_reset) begin
    if (!i_reset) begin
      for (int r = 0; r < WIN_ROWS; r++) begin
        lane_b_q[r] <= '0;
      end
    end else if (i_prime_wr) begin
      lane_b_q[i_row] <= i_prime_data;
    end
  end

  // Word index is 2*row + lane, index 0 in the low bits.
  for (genvar r = 0; r < WIN_ROWS; r++) begin : g_row
    assign o_window[(2*r)*SYM_W +: SYM_W]   = lane_a_q[r];
    assign o_window[(2*r+1)*SYM_W +: SYM_W] = lane_b_q[r];
  end

endmodule

// File: design/match_finder.sv
`timescale 1ns/10ps

module match_finder import lz_pkg::*; (
  input  logic [WIN_WORDS*SYM_W-1:0] i_window,
  input  logic [SYM_W-1:0]           i_sym,
  input  logic [IDX_W-1:0]           i_run_idx,
  output logic                       o_hit,
  output logic [IDX_W-1:0]           o_hit_idx,
  output logic                       o_cont
);

  logic [WIN_WORDS-1:0] eq;
  logic [SYM_W-1:0]     run_word;

  for (genvar i = 0; i < WIN_WORDS; i++) begin : g_cmp
    assign eq[i] = (i_window[i*SYM_W +: SYM_W] == i_sym);
  end

  assign o_hit = |eq;

  // Lowest matching index wins.
  always_comb begin
    o_hit_idx = '0;
    for (int i = WIN_WORDS - 1; i >= 0; i--) begin
      if (eq[i]) begin
        o_hit_idx = IDX_W'(i);
      end
    end
  end

  // Continuation looks only at the word the run is locked to.
  assign run_word = i_window[i_run_idx*SYM_W +: SYM_W];
  assign o_cont   = (run_word == i_sym);

endmodule

// File: design/run_counter.sv
`timescale 1ns/10ps

module run_counter import lz_pkg::*; #(
  parameter int MAX_RUN = 15
) (
  input  logic             clk_i,
  input  logic             i_reset,
  input  logic             i_start,
  input  logic             i_inc,
  output logic [LEN_W-1:0] o_len,
  output logic             o_at_max
);

  localparam logic [LEN_W-1:0] LEN_MAX = LEN_W'(MAX_RUN);

  logic [LEN_W-1:0] len_q;

  always_ff @(posedge clk_i or negedge i_reset) begin
    if (!i_reset) begin
      len_q <= '0;
    end else if (i_start) begin
      len_q <= LEN_W'(1); // First symbol of the run.
    end else if (i_inc) begin
      len_q <= len_q + 1'b1;
    end
  end

  assign o_len    = len_q;
  assign o_at_max = (len_q == LEN_MAX);

endmodule

// File: design/lz_encoder_fsm.sv
`timescale 1ns/10ps

module lz_encoder_fsm import lz_pkg::*; (
  input  logic              clk_i,
  input  logic              i_reset,
  input  logic              i_wr,
  input  logic [SYM_W-1:0]  i_sym,
  input  logic              i_flush,
  input  logic              i_hit,
  input  logic [IDX_W-1:0]  i_hit_idx,
  input  logic              i_cont,
  input  logic [LEN_W-1:0]  i_len,
  input  logic              i_at_max,
  output logic [IDX_W-1:0]  o_run_idx,
  output logic              o_start,
  output logic              o_inc,
  output logic              o_token_valid,
  output logic [KIND_W-1:0] o_token_kind,
  output lz_token_u         o_token
);

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_RUN  = 1'b1;

  logic              state_q, state_d;
  logic [IDX_W-1:0]  run_idx_q, run_idx_d;
  logic              valid_d;
  logic [KIND_W-1:0] kind_d;
  lz_token_u         token_d;

  always_comb begin
    state_d   = state_q;
    run_idx_d = run_idx_q;
    o_start   = 1'b0;
    o_inc     = 1'b0;
    valid_d   = 1'b0;
    kind_d    = KIND_LIT;
    token_d   = '0;
    case (state_q)
      ST_IDLE: begin
        if (i_wr && !i_hit) begin
          valid_d           = 1'b1;
          token_d.lit.sym   = i_sym; // Pad stays zero.
        end else if (i_wr) begin
          o_start   = 1'b1;
          run_idx_d = i_hit_idx;
          state_d   = ST_RUN;
        end
      end
      default: begin
        if (i_wr && i_cont && !i_at_max) begin
          o_inc = 1'b1;
        end else if (i_wr || i_flush) begin
          valid_d           = 1'b1;
          token_d.match.idx = run_idx_q;
          token_d.match.len = i_len;
          state_d           = ST_IDLE;
          if (i_wr && !i_cont) begin
            kind_d             = KIND_MATCH;
            token_d.match.next = i_sym; // Breaking symbol closes the run.
          end else begin
            kind_d = KIND_MATCH_END; // Cap reached or flush.
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge i_reset) begin
    if (!i_reset) begin
      state_q       <= ST_IDLE;
      run_idx_q     <= '0;
      o_token_valid <= 1'b0;
    end else begin
      state_q       <= state_d;
      run_idx_q     <= run_idx_d;
      o_token_valid <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_d) begin
      o_token_kind <= kind_d;
      o_token      <= token_d;
    end
  end

  assign o_run_idx = run_idx_q;

endmodule

// File: design/lz_window_top.sv
`timescale 1ns/10ps

module lz_window_top import lz_pkg::*; #(
  parameter int MAX_RUN = 15
) (
  input  logic              clk_i,
  input  logic              i_reset,
  input  logic              i_wr,
  input  logic [SYM_W-1:0]  i_data,
  input  logic              i_prime_wr,
  input  logic [SYM_W-1:0]  i_prime_data,
  input  logic              i_flush,
  output logic              o_token_valid,
  output logic [KIND_W-1:0] o_token_kind,
  output lz_token_u         o_token,
  output logic              o_full
);

  logic [ROW_W-1:0]           row;
  logic [WIN_WORDS*SYM_W-1:0] window;
  logic                       hit;
  logic [IDX_W-1:0]           hit_idx;
  logic                       cont;
  logic [IDX_W-1:0]           run_idx;
  logic                       start;
  logic                       inc;
  logic [LEN_W-1:0]           len;
  logic                       at_max;

  dict_ptr_gen dict_ptr_gen_i (
    .clk_i      (clk_i),
    .i_reset    (i_reset),
    .i_wr       (i_wr),
    .i_prime_wr (i_prime_wr),
    .o_row      (row),
    .o_full     (o_full)
  );

  dict_window dict_window_i (
    .clk_i        (clk_i),
    .i_reset      (i_reset),
    .i_row        (row),
    .i_wr         (i_wr),
    .i_data       (i_data),
    .i_prime_wr   (i_prime_wr),
    .i_prime_data (i_prime_data),
    .o_window     (window)
  );

  // Search sees the window before this cycle's write.
  match_finder match_finder_i (
    .i_window  (window),
    .i_sym     (i_data),
    .i_run_idx (run_idx),
    .o_hit     (hit),
    .o_hit_idx (hit_idx),
    .o_cont    (cont)
  );

  run_counter #(
    .MAX_RUN (MAX_RUN)
  ) run_counter_i (
    .clk_i    (clk_i),
    .i_reset  (i_reset),
    .i_start  (start),
    .i_inc    (inc),
    .o_len    (len),
    .o_at_max (at_max)
  );

  lz_encoder_fsm lz_encoder_fsm_i (
    .clk_i         (clk_i),
    .i_reset       (i_reset),
    .i_wr          (i_wr),
    .i_sym         (i_data),
    .i_flush       (i_flush),
    .i_hit         (hit),
    .i_hit_idx     (hit_idx),
    .i_cont        (cont),
    .i_len         (len),
    .i_at_max      (at_max),
    .o_run_idx     (run_idx),
    .o_start       (start),
    .o_inc         (inc),
    .o_token_valid (o_token_valid),
    .o_token_kind  (o_token_kind),
    .o_token       (o_token)
  );

endmodule

// File: dv/lz_window_props.sv
`timescale 1ns/10ps

module lz_window_props import lz_pkg::*; #(
  parameter int MAX_RUN = 15
) (
  input logic              clk_i,
  input logic              i_reset,
  input logic              i_wr,
  input logic              i_flush,
  input logic              o_token_valid,
  input logic [KIND_W-1:0] o_token_kind,
  input lz_token_u         o_token
);

  localparam logic [LEN_W-1:0] LEN_MAX = LEN_W'(MAX_RUN);

  int fail_cnt = 0; // Read by the testbench at the end of the run.

  // Token register is cleared with reset.
  a_quiet_in_reset: assert property (@(posedge clk_i) !i_reset |-> !o_token_valid)
    else begin
      fail_cnt++;
      $error("token valid seen while reset is asserted");
    end

  // Every token is caused by a symbol or a flush one cycle earlier.
  a_valid_has_cause: assert property (@(posedge clk_i) disable iff (!i_reset)
    o_token_valid |-> $past(i_wr || i_flush))
    else begin
      fail_cnt++;
      $error("token valid without a write or flush in the previous cycle");
    end

  a_no_flush_with_wr: assert property (@(posedge clk_i) disable iff (!i_reset)
    !(i_wr && i_flush))
    else begin
      fail_cnt++;
      $error("flush and write strobes high in the same cycle");
    end

  a_lit_pad_zero: assert property (@(posedge clk_i) disable iff (!i_reset)
    (o_token_valid && o_token_kind == KIND_LIT) |-> (o_token.lit.pad == '0))
    else begin
      fail_cnt++;
      $error("literal token with nonzero pad bits");
    end

  a_len_in_range: assert property (@(posedge clk_i) disable iff (!i_reset)
    (o_token_valid && o_token_kind != KIND_LIT) |->
      (o_token.match.len != '0 && o_token.match.len <= LEN_MAX))
    else begin
      fail_cnt++;
      $error("match token length outside 1 to MAX_RUN");
    end

endmodule

bind lz_window_top lz_window_props #(
  .MAX_RUN (MAX_RUN)
) props_i (
  .clk_i         (clk_i),
  .i_reset       (i_reset),
  .i_wr          (i_wr),
  .i_flush       (i_flush),
  .o_token_valid (o_token_valid),
  .o_token_kind  (o_token_kind),
  .o_token       (o_token)
);

// File: dv/lz_window_tb.sv
`timescale 1ns/10ps

module lz_window_tb import lz_pkg::*; ();

  localparam int MAX_RUN        = 6;
  localparam int RESET_CYCLES   = 2;
  localparam int NUM_CYCLES     = 2000;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + 200; // Margin over reset and the last check.

  logic              clk_i;
  logic              i_reset;
  logic              i_wr;
  logic [SYM_W-1:0]  i_data;
  logic              i_prime_wr;
  logic [SYM_W-1:0]  i_prime_data;
  logic              i_flush;
  logic              o_token_valid;
  logic [KIND_W-1:0] o_token_kind;
  lz_token_u         o_token;
  logic              o_full;

  // Reference model state.
  logic [SYM_W-1:0]  m_win [WIN_WORDS];
  logic [ROW_W-1:0]  m_ptr;
  logic              m_run;
  logic [IDX_W-1:0]  m_idx;
  logic [LEN_W-1:0]  m_len;
  logic              exp_valid;
  logic [KIND_W-1:0] exp_kind;
  lz_token_u         exp_tok;

  logic [SYM_W-1:0] alphabet [4] = '{8'h00, 8'h61, 8'h62, 8'h63};
  logic [SYM_W-1:0] last_sym;

  int seed = 14510;
  int cycle_cnt;
  int checks;
  int token_errs;
  int valid_errs;
  int full_errs;
  int cover_errs;
  int assert_errs;
  int lit_cnt;
  int match_cnt;
  int cap_cnt;
  int flush_cnt;
  int odd_cnt;

  lz_window_top #(
    .MAX_RUN (MAX_RUN)
  ) lz_window_top_i (
    .clk_i         (clk_i),
    .i_reset       (i_reset),
    .i_wr          (i_wr),
    .i_data        (i_data),
    .i_prime_wr    (i_prime_wr),
    .i_prime_data  (i_prime_data),
    .i_flush       (i_flush),
    .o_token_valid (o_token_valid),
    .o_token_kind  (o_token_kind),
    .o_token       (o_token),
    .o_full        (o_full)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic model_reset();
    for (int i = 0; i < WIN_WORDS; i++) begin
      m_win[i] = '0;
    end
    m_ptr     = '0;
    m_run     = 1'b0;
    m_idx     = '0;
    m_len     = '0;
    exp_valid = 1'b0;
  endtask

  // Predicts the token for the coming edge, then applies this cycle's writes.
  task automatic model_step(input logic wr, input logic [SYM_W-1:0] d,
                            input logic pwr, input logic [SYM_W-1:0] pd, input logic fl);
    logic             hit;
    logic [IDX_W-1:0] hit_idx;
    hit       = 1'b0;
    hit_idx   = '0;
    exp_valid = 1'b0;
    exp_kind  = KIND_LIT;
    exp_tok   = '0;
    for (int i = 0; i < WIN_WORDS; i++) begin
      if (!hit && m_win[i] == d) begin
        hit     = 1'b1;
        hit_idx = IDX_W'(i);
      end
    end
    if (!m_run) begin
      if (wr && !hit) begin
        exp_valid       = 1'b1;
        exp_tok.lit.sym = d;
        lit_cnt++;
      end else if (wr) begin
        m_run = 1'b1;
        m_idx = hit_idx;
        m_len = LEN_W'(1);
        if (hit_idx[0]) begin
          odd_cnt++; // Run locked to a priming word.
        end
      end
    end else if (wr && m_win[m_idx] == d && m_len != LEN_W'(MAX_RUN)) begin
      m_len = m_len + 1'b1;
    end else if (wr || fl) begin
      exp_valid         = 1'b1;
      exp_tok.match.idx = m_idx;
      exp_tok.match.len = m_len;
      m_run             = 1'b0;
      if (wr && m_win[m_idx] != d) begin
        exp_kind           = KIND_MATCH;
        exp_tok.match.next = d;
        match_cnt++;
      end else begin
        exp_kind = KIND_MATCH_END;
        if (wr) begin
          cap_cnt++;
        end else begin
          flush_cnt++;
        end
      end
    end
    if (wr) begin
      m_win[{m_ptr, 1'b0}] = d;
    end
    if (pwr) begin
      m_win[{m_ptr, 1'b1}] = pd;
    end
    if (wr || pwr) begin
      m_ptr = (m_ptr == ROW_W'(WIN_ROWS - 1)) ? '0 : m_ptr + 1'b1;
    end
  endtask

  task automatic drive_random(input logic first);
    logic [31:0] r;
    r          = $random(seed);
    i_wr       = (r[1:0] != 2'b00);
    i_prime_wr = (r[4:2] == 3'b000);
    i_flush    = !i_wr && r[5];
    if (r[7]) begin
      i_data = last_sym; // Repeats stretch runs toward the cap.
    end else if (r[10:8] == 3'b000) begin
      i_data = {1'b1, r[22:16]}; // Rare wide symbol, mostly a literal.
    end else begin
      i_data = alphabet[r[12:11]];
    end
    i_prime_data = alphabet[r[14:13]];
    if (first) begin
      // Zero window, so symbol 0 opens a run at index 0.
      i_wr       = 1'b1;
      i_data     = '0;
      i_prime_wr = 1'b0;
      i_flush    = 1'b0;
    end
    if (i_wr) begin
      last_sym = i_data;
    end
  endtask

  task automatic check_token(input lz_token_u exp_t, input logic [KIND_W-1:0] exp_k);
    checks++;
    if (o_token_kind !== exp_k || o_token !== exp_t) begin
      token_errs++;
      $display("error at %0t: token kind %0d value %h, expected kind %0d value %h",
               $time, o_token_kind, o_token, exp_k, exp_t);
    end
  endtask

  task automatic check_valid(input logic exp_v);
    checks++;
    if (o_token_valid !== exp_v) begin
      valid_errs++;
      $display("error at %0t: token valid %b, expected %b", $time, o_token_valid, exp_v);
    end
  endtask

  task automatic check_full(input logic exp_f);
    checks++;
    if (o_full !== exp_f) begin
      full_errs++;
      $display("error at %0t: full flag %b, expected %b", $time, o_full, exp_f);
    end
  endtask

  task automatic require_seen(input int count, input string what);
    if (count == 0) begin
      cover_errs++;
      $display("random stimulus never produced %s", what);
    end
  endtask

  initial begin
    clk_i        = 1'b0;
    i_reset      = 1'b0;
    i_wr         = 1'b0;
    i_data       = '0;
    i_prime_wr   = 1'b0;
    i_prime_data = '0;
    i_flush      = 1'b0;
    last_sym     = '0;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    i_reset = 1'b1;
    check_valid(1'b0);
    check_full(1'b0);
    for (int n = 0; n < NUM_CYCLES; n++) begin
      drive_random(n == 0);
      model_step(i_wr, i_data, i_prime_wr, i_prime_data, i_flush);
      @(posedge clk_i);
      #1;
      check_valid(exp_valid);
      if (exp_valid) begin
        check_token(exp_tok, exp_kind);
      end
      check_full(m_ptr == ROW_W'(WIN_ROWS - 1));
    end
    i_wr       = 1'b0;
    i_prime_wr = 1'b0;
    i_flush    = 1'b0;
    require_seen(lit_cnt, "a literal token");
    require_seen(match_cnt, "a match token");
    require_seen(cap_cnt, "a run that hit the length cap");
    require_seen(flush_cnt, "a flushed run");
    require_seen(odd_cnt, "a run on a priming word");
    assert_errs = lz_window_top_i.props_i.fail_cnt;
    $display("checks %0d, errors: token %0d valid %0d full %0d coverage %0d assertion %0d; ",
             checks, token_errs, valid_errs, full_errs, cover_errs, assert_errs,
             "tokens: lit %0d match %0d cap %0d flush %0d",
             lit_cnt, match_cnt, cap_cnt, flush_cnt);
    if (token_errs + valid_errs + full_errs + cover_errs + assert_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tb.f
design/lz_pkg.sv
design/dict_ptr_gen.sv
design/dict_window.sv
design/match_finder.sv
design/run_counter.sv
design/lz_encoder_fsm.sv
design/lz_window_top.sv
dv/lz_window_props.sv
dv/lz_window_tb.sv

// File: Makefile
SIM       := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := lz_window_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
